/* rtl/tx_bit_pkg.sv */
// shared widths, descriptor and buffer write structs, controller states, queue types
package tx_bit_pkg;

    localparam int DATA_W     = 64;  // payload and buffer word
    localparam int TSF_W      = 64;  // packet timestamp and running tsf
    localparam int NUM_QUEUES = 3;
    localparam int CSMA_QUEUE = 2;   // contention based, no time slot
    localparam int LEN_W      = 13;  // word count and write address width

    typedef logic [1:0]            queue_idx_t;
    typedef logic [NUM_QUEUES-1:0] queue_mask_t;

    // descriptor as popped from a queue, lsb at the bottom
    typedef struct packed {
        logic [31:0]      rsvd_hi;
        logic [1:0]       prio;           // linux priority
        logic [9:0]       sn;             // sequence number
        logic [1:0]       rsvd_lo;
        logic [3:0]       retrans_limit;
        logic             need_ack;
        logic [LEN_W-1:0] num_words;      // payload words, 1 .. buffer depth
    } tx_desc_t;

    // controller side write port of the packet buffer
    typedef struct packed {
        logic              we;
        logic [LEN_W-1:0]  addr;  // buffer keeps the low BUF_ADDR_W bits
        logic [DATA_W-1:0] data;
    } buf_wr_t;

    typedef enum logic [2:0] {
        st_wait_chance,
        st_fetch_desc,
        st_tdma_judge,
        st_csma_judge,
        st_do_tx,
        st_drop_pkt
    } ctrl_state_t;

endpackage

/* rtl/tx_bit_ctrl.sv */
// transmit controller with queue arbitration, descriptor fetch, tdma/csma judge, copy/drop, status
module tx_bit_ctrl import tx_bit_pkg::*; (
    input  logic              clk,
    input  logic              rstn,
    input  queue_mask_t       allowed,
    input  queue_mask_t       desc_empty,
    input  tx_desc_t          desc_data,
    input  logic [TSF_W-1:0]  tsf_data,
    input  logic [DATA_W-1:0] data_in,
    input  logic              data_valid,
    input  logic [TSF_W-1:0]  tsf_runtime,
    input  logic              tx_bb_busy,
    input  logic              tx_end,
    input  logic              tx_try_complete,
    output logic              desc_pop,
    output logic              tsf_pop,
    output logic              data_pop,
    output queue_idx_t        tx_queue_idx,
    output buf_wr_t           buf_wr,
    output tx_desc_t          cur_desc,
    output logic [9:0]        tx_pkt_sn,
    output logic [1:0]        linux_prio
);

    ctrl_state_t       state;
    logic [TSF_W-1:0]  tsf_pkt;      // timestamp of the packet in flight
    logic [LEN_W-1:0]  word_cnt;     // payload words consumed so far
    logic              consume;
    logic              last_word;
    logic              grant_vld;
    queue_idx_t        grant_idx;

    logic              buf_we;
    logic [LEN_W-1:0]  wr_addr;
    logic [DATA_W-1:0] wr_data;

    // fixed priority, lowest index wins
    always_comb begin
        grant_vld = 1'b0;
        grant_idx = '0;
        for (int i = NUM_QUEUES - 1; i >= 0; i--) begin
            if (allowed[i] && !desc_empty[i]) begin
                grant_vld = 1'b1;
                grant_idx = queue_idx_t'(i);
            end
        end
        grant_vld = grant_vld && !tx_bb_busy;  // baseband must be idle
    end

    assign consume   = data_pop && data_valid;
    assign last_word = (word_cnt == cur_desc.num_words - LEN_W'(1));

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state        <= st_wait_chance;
            desc_pop     <= 1'b0;
            tsf_pop      <= 1'b0;
            data_pop     <= 1'b0;
            tx_queue_idx <= '0;
            cur_desc     <= '0;
            word_cnt     <= '0;
            buf_we       <= 1'b0;
        end else begin
            buf_we <= (state == st_do_tx) && consume;
            case (state)
                st_wait_chance: begin
                    word_cnt <= '0;
                    data_pop <= 1'b0;
                    if (grant_vld) begin
                        desc_pop     <= 1'b1;  // descriptor and timestamp together
                        tsf_pop      <= 1'b1;
                        tx_queue_idx <= grant_idx;
                        state        <= st_fetch_desc;
                    end
                end

                st_fetch_desc: begin
                    // fifo heads valid in the pop cycle
                    desc_pop <= 1'b0;
                    tsf_pop  <= 1'b0;
                    cur_desc <= desc_data;
                    if (tx_queue_idx == queue_idx_t'(CSMA_QUEUE)) begin
                        state <= st_csma_judge;
                    end else begin
                        state <= st_tdma_judge;
                    end
                end

                st_tdma_judge: begin
                    if (tsf_pkt < tsf_runtime) begin  // slot already passed
                        data_pop <= 1'b1;
                        state    <= st_drop_pkt;
                    end else if (tsf_pkt == tsf_runtime) begin
                        data_pop <= 1'b1;
                        state    <= st_do_tx;
                    end
                end

                st_csma_judge: begin
                    data_pop <= 1'b1;  // no slot to wait for
                    state    <= st_do_tx;
                end

                st_do_tx: begin
                    if (consume) begin
                        word_cnt <= word_cnt + LEN_W'(1);
                        if (last_word) begin
                            data_pop <= 1'b0;
                        end
                    end
                    // phy done, copy already finished
                    if (tx_end && !data_pop) begin
                        state <= st_wait_chance;
                    end
                end

                st_drop_pkt: begin
                    if (consume) begin
                        word_cnt <= word_cnt + LEN_W'(1);
                        if (last_word) begin
                            data_pop <= 1'b0;
                            state    <= st_wait_chance;
                        end
                    end
                end

                default: begin
                    state <= st_wait_chance;
                end
            endcase
        end
    end

    // timestamp and write payload
    always_ff @(posedge clk) begin
        if (state == st_fetch_desc) begin
            tsf_pkt <= tsf_data;
        end
        wr_addr <= word_cnt;  // address of the word consumed this cycle
        wr_data <= data_in;
    end

    always_comb begin
        buf_wr.we   = buf_we;
        buf_wr.addr = wr_addr;
        buf_wr.data = wr_data;
    end

    // status of the current packet, reported when the mac attempt ends
    always_ff @(posedge clk) begin
        if (!rstn) begin
            tx_pkt_sn  <= '0;
            linux_prio <= '0;
        end else if (tx_try_complete) begin
            tx_pkt_sn  <= cur_desc.sn;
            linux_prio <= cur_desc.prio;
        end
    end

endmodule

/* rtl/tx_start_gen.sv */
// phy start pulse generator driven by the buffer write stream
module tx_start_gen import tx_bit_pkg::*; #(
    parameter int BUF_ADDR_W      = 10,
    parameter int START_PULSE_LEN = 6
) (
    input  logic                  clk,
    input  logic                  rstn,
    input  buf_wr_t               buf_wr,
    input  logic [BUF_ADDR_W-1:0] start_th,
    output logic                  start
);

    localparam int CNT_W = $clog2(START_PULSE_LEN + 1);

    logic [CNT_W-1:0] pulse_cnt;  // cycles of pulse left
    logic             th_hit;

    // only a real write counts, compared on the bits the buffer decodes
    assign th_hit = buf_wr.we && (buf_wr.addr[BUF_ADDR_W-1:0] == start_th);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            pulse_cnt <= '0;
        end else if (th_hit) begin
            pulse_cnt <= CNT_W'(START_PULSE_LEN);  // restart on a new hit
        end else if (pulse_cnt != '0) begin
            pulse_cnt <= pulse_cnt - CNT_W'(1);
        end
    end

    assign start = (pulse_cnt != '0);

endmodule

/* rtl/tx_pkt_buffer.sv */
// true dual-port packet ram, controller write/read port and phy read port
module tx_pkt_buffer import tx_bit_pkg::*; #(
    parameter int BUF_ADDR_W = 10
) (
    input  logic                  clk,
    input  buf_wr_t               buf_wr,
    input  logic [BUF_ADDR_W-1:0] rd_addr,
    output logic [DATA_W-1:0]     douta,
    output logic [DATA_W-1:0]     rd_data
);

    localparam int DEPTH = 2 ** BUF_ADDR_W;

    logic [DATA_W-1:0]     mem [DEPTH];
    logic [BUF_ADDR_W-1:0] addr_a;

    assign addr_a = buf_wr.addr[BUF_ADDR_W-1:0];  // upper bits dropped

    // port a, write first
    always_ff @(posedge clk) begin
        if (buf_wr.we) begin
            mem[addr_a] <= buf_wr.data;
            douta       <= buf_wr.data;
        end else begin
            douta <= mem[addr_a];
        end
    end

    // port b, phy side
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

/* rtl/tx_bit_intf.sv */
// transmit bit interface top, controller plus start generator plus packet buffer
module tx_bit_intf import tx_bit_pkg::*; #(
    parameter int BUF_ADDR_W      = 10,
    parameter int START_PULSE_LEN = 6
) (
    input  logic                  clk,
    input  logic                  rstn,

    // descriptor and timestamp fifos
    input  queue_mask_t           allowed,
    input  queue_mask_t           desc_empty,
    input  tx_desc_t              desc_data,
    output logic                  desc_pop,
    output queue_idx_t            tx_queue_idx,
    input  logic [TSF_W-1:0]      tsf_data,
    output logic                  tsf_pop,

    // shared payload fifo
    input  logic [DATA_W-1:0]     data_in,
    input  logic                  data_valid,
    output logic                  data_pop,

    // mac side
    input  logic [TSF_W-1:0]      tsf_runtime,
    input  logic                  tx_bb_busy,
    input  logic                  tx_try_complete,
    input  logic [BUF_ADDR_W-1:0] start_th,
    output logic                  tx_pkt_need_ack,
    output logic [3:0]            tx_pkt_retrans_limit,
    output logic [9:0]            tx_pkt_sn,
    output logic [1:0]            linux_prio,
    output logic [DATA_W-1:0]     douta,

    // phy
    input  logic                  tx_end,
    input  logic [BUF_ADDR_W-1:0] bram_addr,
    output logic [DATA_W-1:0]     bram_data,
    output logic                  start
);

    buf_wr_t  buf_wr;
    tx_desc_t cur_desc;

    tx_bit_ctrl u_ctrl (
        .clk             (clk),
        .rstn            (rstn),
        .allowed         (allowed),
        .desc_empty      (desc_empty),
        .desc_data       (desc_data),
        .tsf_data        (tsf_data),
        .data_in         (data_in),
        .data_valid      (data_valid),
        .tsf_runtime     (tsf_runtime),
        .tx_bb_busy      (tx_bb_busy),
        .tx_end          (tx_end),
        .tx_try_complete (tx_try_complete),
        .desc_pop        (desc_pop),
        .tsf_pop         (tsf_pop),
        .data_pop        (data_pop),
        .tx_queue_idx    (tx_queue_idx),
        .buf_wr          (buf_wr),
        .cur_desc        (cur_desc),
        .tx_pkt_sn       (tx_pkt_sn),
        .linux_prio      (linux_prio)
    );

    tx_start_gen #(
        .BUF_ADDR_W      (BUF_ADDR_W),
        .START_PULSE_LEN (START_PULSE_LEN)
    ) u_start_gen (
        .clk      (clk),
        .rstn     (rstn),
        .buf_wr   (buf_wr),
        .start_th (start_th),
        .start    (start)
    );

    tx_pkt_buffer #(
        .BUF_ADDR_W (BUF_ADDR_W)
    ) u_pkt_buffer (
        .clk     (clk),
        .buf_wr  (buf_wr),
        .rd_addr (bram_addr),
        .douta   (douta),
        .rd_data (bram_data)
    );

    // status fields straight from the packet in flight
    assign tx_pkt_need_ack      = cur_desc.need_ack;
    assign tx_pkt_retrans_limit = cur_desc.retrans_limit;

endmodule

/* test/tb_ref.svh */
// testbench helpers with the lcg, reference packet model, fifo drive and typed compare tasks
`ifndef TB_REF_SVH
`define TB_REF_SVH

typedef logic [DATA_W-1:0] word_q_t[$];

logic [31:0] lcg_state = 32'd47198;

function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return {16'h0, lcg_state[30:15]};  // low bits of an lcg cycle too fast
endfunction

// payload word built from 16 bit slices so every bit toggles
function automatic logic [DATA_W-1:0] rand_word();
    logic [DATA_W-1:0] w;
    w = '0;
    for (int i = 0; i < DATA_W / 16; i++) begin
        w = {w[DATA_W-17:0], 16'(lcg_next())};
    end
    return w;
endfunction

function automatic tx_desc_t make_desc();
    tx_desc_t d;
    d               = '0;
    d.num_words     = LEN_W'(8 + (lcg_next() % 33));  // 8 .. 40 words
    d.need_ack      = 1'(lcg_next() % 2);
    d.retrans_limit = 4'(lcg_next());
    d.sn            = 10'(lcg_next());
    d.prio          = 2'(lcg_next());
    return d;
endfunction

// expected buffer contents and status of one transmitted packet
function automatic void ref_expect(input tx_desc_t d, input word_q_t words,
                                   output word_q_t exp_mem, output tx_desc_t exp_status);
    exp_mem = {};
    for (int i = 0; i < int'(d.num_words); i++) begin
        exp_mem.push_back(words[i]);  // word i lands at address i
    end
    exp_status               = '0;
    exp_status.sn            = d.sn;
    exp_status.prio          = d.prio;
    exp_status.need_ack      = d.need_ack;
    exp_status.retrans_limit = d.retrans_limit;
endfunction

// first word fall through fifo heads
task automatic drive_fifos();
    for (int i = 0; i < NUM_QUEUES; i++) begin
        desc_empty[i] = (desc_q[i].size() == 0);
    end
    if (int'(tx_queue_idx) < NUM_QUEUES && desc_q[tx_queue_idx].size() > 0) begin
        desc_data = desc_q[tx_queue_idx][0];
    end else begin
        desc_data = '0;
    end
    tsf_data   = (tsf_q.size() > 0) ? tsf_q[0] : '0;
    data_in    = (pay_q.size() > 0) ? pay_q[0] : '0;
    data_valid = (pay_q.size() > 0) && ((lcg_next() % 4) != 0);  // random gaps
endtask

task automatic check_word(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
                          input string what);
    if (got !== exp) begin
        report_mismatch($sformatf("%s got %h expected %h", what, got, exp));
    end
endtask

task automatic check_queue(input queue_idx_t got, input queue_idx_t exp);
    if (got !== exp) begin
        report_mismatch($sformatf("popped queue %0d expected %0d", got, exp));
    end
endtask

task automatic check_desc_status(input tx_desc_t exp);
    if (tx_pkt_sn !== exp.sn || linux_prio !== exp.prio) begin
        report_mismatch($sformatf("sn/prio %0d/%0d expected %0d/%0d",
                                  tx_pkt_sn, linux_prio, exp.sn, exp.prio));
    end
    if (tx_pkt_need_ack !== exp.need_ack || tx_pkt_retrans_limit !== exp.retrans_limit) begin
        report_mismatch($sformatf("need_ack/retrans_limit %0d/%0d expected %0d/%0d",
                                  tx_pkt_need_ack, tx_pkt_retrans_limit,
                                  exp.need_ack, exp.retrans_limit));
    end
endtask

task automatic check_pulse(input int rises, input int width, input int exp_rises);
    if (rises != exp_rises) begin
        report_mismatch($sformatf("start rose %0d times expected %0d", rises, exp_rises));
    end
    if (exp_rises > 0 && width != START_PULSE_LEN) begin
        report_mismatch($sformatf("start width %0d expected %0d", width, START_PULSE_LEN));
    end
endtask

`endif

/* test/tx_bit_intf_tb.sv */
// testbench top for the transmit bit interface with clock, reset, fifo models, checks and timeout
module tx_bit_intf_tb import tx_bit_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int BUF_ADDR_W      = 10;
    localparam int START_PULSE_LEN = 6;
    localparam int START_TH        = 4;
    localparam int RST_CYCLES      = 10;
    localparam int NUM_PKTS        = 5;
    localparam int MAX_WORDS       = 40;
    localparam int CYCLE_LIMIT     = RST_CYCLES + NUM_PKTS * (MAX_WORDS + 200);

    logic clk, rstn;
    queue_mask_t allowed, desc_empty;
    tx_desc_t desc_data;
    logic desc_pop, tsf_pop, data_pop, data_valid;
    queue_idx_t tx_queue_idx;
    logic [TSF_W-1:0] tsf_data, tsf_runtime;
    logic [DATA_W-1:0] data_in, douta, bram_data;
    logic tx_bb_busy, tx_try_complete, tx_end, start;
    logic [BUF_ADDR_W-1:0] start_th, bram_addr;
    logic tx_pkt_need_ack;
    logic [3:0] tx_pkt_retrans_limit;
    logic [9:0] tx_pkt_sn;
    logic [1:0] linux_prio;

    // fifo models
    tx_desc_t desc_q[NUM_QUEUES][$];
    logic [TSF_W-1:0] tsf_q[$];
    logic [DATA_W-1:0] pay_q[$];

    int consumed, pop_count, cycle_cnt;
    queue_idx_t pop_idx;
    int start_rises, start_run, start_width;
    logic start_prev;

    logic copy_on;                  // douta follows the buffer writes
    logic [1:0] wr_pend;            // copied words still on their way to douta
    logic [DATA_W-1:0] wr_word[2];

    `include "tb_ref.svh"

    tx_bit_intf #(
        .BUF_ADDR_W      (BUF_ADDR_W),
        .START_PULSE_LEN (START_PULSE_LEN)
    ) DUT (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic report_mismatch(input string msg);
        $display("FAIL @ %0t ns: %s", $time, msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "first mismatch");
    endtask

    // sample at the edge and drive 1 ns later
    task automatic step();
        logic took;
        logic popped;
        logic ts_popped;
        queue_idx_t idx;
        @(posedge clk);
        took      = data_pop && data_valid;
        popped    = desc_pop;
        ts_popped = tsf_pop;
        idx       = tx_queue_idx;
        if (ts_popped !== popped) report_mismatch("tsf_pop not together with desc_pop");
        // write first port returns a copied word two edges after it is consumed
        if (wr_pend[1]) check_word(douta, wr_word[1], "douta after write");
        wr_pend    = {wr_pend[0], copy_on && took};
        wr_word[1] = wr_word[0];
        wr_word[0] = data_in;
        if (start && !start_prev) start_rises++;
        if (start) begin
            start_run++;
        end else if (start_prev) begin
            start_width = start_run;
            start_run   = 0;
        end
        start_prev = start;
        cycle_cnt++;
        if (cycle_cnt > CYCLE_LIMIT) begin
            $display("timeout, the run went past %0d cycles", CYCLE_LIMIT);
            $display("TEST RESULT: FAIL");
            $fatal(1, "timeout");
        end
        #1;
        if (took) begin
            void'(pay_q.pop_front());
            consumed++;
        end
        if (popped) begin
            void'(desc_q[idx].pop_front());
            pop_count++;
            pop_idx  = idx;
            consumed = 0;
        end
        if (ts_popped) void'(tsf_q.pop_front());
        drive_fifos();
    endtask

    task automatic push_pkt(input int q, input logic [TSF_W-1:0] ts,
                            output tx_desc_t d, output word_q_t w);
        d = make_desc();
        w = {};
        for (int i = 0; i < int'(d.num_words); i++) begin
            w.push_back(rand_word());
        end
        desc_q[q].push_back(d);
        tsf_q.push_back(ts);
        foreach (w[i]) pay_q.push_back(w[i]);
    endtask

    task automatic wait_pop(input queue_idx_t exp_q);
        int pc;
        pc          = pop_count;
        start_rises = 0;
        start_width = 0;
        while (pop_count == pc) step();
        check_queue(pop_idx, exp_q);
    endtask

    task automatic run_tx(input tx_desc_t d, input word_q_t w, input logic [TSF_W-1:0] ts,
                          input logic hold);
        word_q_t exp_mem;
        tx_desc_t exp_status;
        int pc;
        pc = pop_count;
        ref_expect(d, w, exp_mem, exp_status);
        copy_on = 1'b1;
        if (hold) begin
            while (tsf_runtime < ts) begin
                step();
                if (data_pop) report_mismatch("data_pop before the packet's slot");
                tsf_runtime++;
            end
            step();
            if (!data_pop) report_mismatch("data_pop did not rise at the packet's slot");
        end
        while (consumed < int'(d.num_words)) step();
        repeat (12) step();  // last write and start pulse settle
        copy_on = 1'b0;
        for (int a = 0; a < int'(d.num_words); a++) begin
            bram_addr = BUF_ADDR_W'(a);
            step();
            check_word(bram_data, exp_mem[a], $sformatf("buffer word %0d", a));
        end
        check_pulse(start_rises, start_width, 1);
        tx_try_complete = 1'b1;
        step();
        tx_try_complete = 1'b0;
        step();
        check_desc_status(exp_status);
        if (pop_count != pc) report_mismatch("descriptor popped before tx_end");
        tx_end = 1'b1;
        step();
        tx_end = 1'b0;
        step();
    endtask

    initial begin
        tx_desc_t d0, d1;
        word_q_t w0, w1;
        logic [TSF_W-1:0] ts1;
        rstn            = 1'b0;
        allowed         = '1;
        desc_empty      = '1;
        desc_data       = '0;
        tsf_data        = '0;
        data_in         = '0;
        data_valid      = 1'b0;
        tsf_runtime     = 64'd1000;
        tx_bb_busy      = 1'b0;
        tx_try_complete = 1'b0;
        tx_end          = 1'b0;
        start_th        = BUF_ADDR_W'(START_TH);
        bram_addr       = '0;
        consumed        = 0;
        pop_count       = 0;
        cycle_cnt       = 0;
        pop_idx         = '0;
        start_rises     = 0;
        start_run       = 0;
        start_width     = 0;
        start_prev      = 1'b0;
        copy_on         = 1'b0;
        wr_pend         = '0;
        repeat (RST_CYCLES) step();
        rstn = 1'b1;
        step();

        // csma packet on queue 2
        push_pkt(2, '0, d0, w0);
        wait_pop(2'd2);
        run_tx(d0, w0, '0, 1'b0);

        // queues 0 and 1 ready together with the queue 1 slot in the future
        ts1 = tsf_runtime + 64'd50;
        push_pkt(0, tsf_runtime, d0, w0);
        push_pkt(1, ts1, d1, w1);
        wait_pop(2'd0);
        run_tx(d0, w0, tsf_runtime, 1'b0);
        wait_pop(2'd1);
        run_tx(d1, w1, ts1, 1'b1);

        // stale tdma packet is dropped while queue 2 waits with its words behind
        allowed = 3'b011;
        push_pkt(1, tsf_runtime - 64'd5, d0, w0);
        push_pkt(2, '0, d1, w1);
        wait_pop(2'd1);
        while (consumed < int'(d0.num_words)) step();
        repeat (12) step();
        if (consumed != int'(d0.num_words)) report_mismatch("drop consumed a wrong word count");
        check_pulse(start_rises, start_width, 0);

        // next packet still lands at address 0
        allowed = '1;
        wait_pop(2'd2);
        run_tx(d1, w1, '0, 1'b0);

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

/* vlog.f */
+incdir+test
rtl/tx_bit_pkg.sv
rtl/tx_bit_ctrl.sv
rtl/tx_start_gen.sv
rtl/tx_pkt_buffer.sv
rtl/tx_bit_intf.sv
test/tx_bit_intf_tb.sv

/* Bender.yml */
package:
  name: tx_bit_intf

sources:
  - rtl/tx_bit_pkg.sv
  - rtl/tx_bit_ctrl.sv
  - rtl/tx_start_gen.sv
  - rtl/tx_pkt_buffer.sv
  - rtl/tx_bit_intf.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tx_bit_intf_tb.sv
